/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_mini_mips
RTL_TOP   ?= mini_mips_top
FILELIST  ?= mini_mips_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_mini_mips.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mini_mips;

localparam logic [31:0] reset_pc = 32'h0000_0100;
localparam logic [31:0] marker = 32'h0000_0ffc;

logic        clk;
logic        rst;
logic        ibus_cyc;
logic        ibus_stb;
logic [31:0] ibus_adr;
logic [31:0] ibus_dat_r;
logic        ibus_ack;
logic        dbus_cyc;
logic        dbus_stb;
logic        dbus_we;
logic [3:0]  dbus_sel;
logic [31:0] dbus_adr;
logic [31:0] dbus_dat_w;
logic [31:0] dbus_dat_r;
logic        dbus_ack;

logic [31:0] imem [logic [31:0]];
logic [31:0] dmem [logic [31:0]];
logic [31:0] prog [$];
logic [31:0] exp_adr [$];
logic [31:0] exp_dat [$];
logic [31:0] wr_adr [$];
logic [31:0] wr_dat [$];
logic [31:0] lcg_state;
logic [31:0] alu_a;
logic [31:0] alu_b;
logic [15:0] alu_imm;
logic        random_delay;
logic        marker_seen;
int          i_cnt;
int          i_delay;
int          d_cnt;
int          d_delay;
int          errors;
int          tests_run;
int          tests_failed;

mini_mips_top #(
	.reset_pc ( reset_pc )
) dut (
	.clk, .rst,
	.ibus_cyc, .ibus_stb, .ibus_adr, .ibus_dat_r, .ibus_ack,
	.dbus_cyc, .dbus_stb, .dbus_we, .dbus_sel, .dbus_adr, .dbus_dat_w,
	.dbus_dat_r, .dbus_ack
);

always #10 clk = ~clk;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic int next_delay();
	logic [31:0] r;
	if (!random_delay) begin
		return 1;
	end
	r = lcg_next();
	return int'(r[17:16]);
endfunction

// unused locations decode as an unsupported opcode
function automatic logic [31:0] imem_read(input logic [31:0] a);
	if (imem.exists(a)) begin
		return imem[a];
	end
	return {6'h3f, a[25:0] ^ {20'h0_0000, a[31:26]}};
endfunction

function automatic logic [31:0] dmem_read(input logic [31:0] a);
	if (dmem.exists(a)) begin
		return dmem[a];
	end
	return a ^ 32'ha5a5_5a5a;
endfunction

// instruction memory slave
always @(posedge clk) begin
	#1;
	if (rst || ibus_ack) begin
		ibus_ack = 1'b0;
		i_cnt = 0;
	end else if (ibus_cyc && ibus_stb) begin
		if (i_cnt >= i_delay) begin
			ibus_dat_r = imem_read(ibus_adr);
			ibus_ack = 1'b1;
			i_delay = next_delay();
		end else begin
			i_cnt++;
		end
	end
end

// data memory slave that logs every write
always @(posedge clk) begin
	#1;
	if (rst || dbus_ack) begin
		dbus_ack = 1'b0;
		d_cnt = 0;
	end else if (dbus_cyc && dbus_stb) begin
		if (d_cnt >= d_delay) begin
			// word accesses only
			check_word("dbus_sel", {28'd0, dbus_sel}, 32'h0000_000f);
			if (dbus_we) begin
				dmem[dbus_adr] = dbus_dat_w;
				wr_adr.push_back(dbus_adr);
				wr_dat.push_back(dbus_dat_w);
				if (dbus_adr == marker) begin
					marker_seen = 1'b1;
				end
			end else begin
				dbus_dat_r = dmem_read(dbus_adr);
			end
			dbus_ack = 1'b1;
			d_delay = next_delay();
		end else begin
			d_cnt++;
		end
	end
end

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp) else begin
		$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		errors++;
	end
endtask

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
	return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic emit_li(input logic [4:0] rd, input logic [31:0] val);
	prog.push_back(enc_i(6'h0f, 5'd0, rd, val[31:16]));
	prog.push_back(enc_i(6'h0d, rd, rd, val[15:0]));
endtask

// sw rt, addr(r0) and the write it must produce
task automatic emit_store(input logic [4:0] rt, input logic [15:0] addr, input logic [31:0] val);
	prog.push_back(enc_i(6'h2b, 5'd0, rt, addr));
	exp_adr.push_back({16'h0000, addr});
	exp_dat.push_back(val);
endtask

task automatic apply_reset();
	int i;
	@(posedge clk);
	#1;
	rst = 1'b1;
	wr_adr.delete();
	wr_dat.delete();
	dmem.delete();
	imem.delete();
	marker_seen = 1'b0;
	foreach (prog[k]) begin
		imem[reset_pc + 32'(4 * k)] = prog[k];
	end
	repeat (16) begin
		@(posedge clk);
		#1;
		assert (!ibus_cyc && !ibus_stb && !dbus_cyc && !dbus_stb) else begin
			$display("bus request raised during reset at %0t ns", $time);
			errors++;
		end
	end
	rst = 1'b0;
	for (i = 0; i < 20 && !ibus_cyc; i++) begin
		@(posedge clk);
		#1;
	end
	assert (ibus_cyc) else begin
		$display("timeout: no instruction fetch after reset");
		errors++;
	end
	check_word("ibus_adr", ibus_adr, reset_pc);
endtask

task automatic run_program(input string name);
	int i;
	int start_errors;
	start_errors = errors;
	prog.push_back(enc_i(6'h2b, 5'd0, 5'd0, marker[15:0]));
	exp_adr.push_back(marker);
	exp_dat.push_back(32'd0);
	apply_reset();
	for (i = 0; i < 4000 && !marker_seen; i++) begin
		@(posedge clk);
	end
	assert (marker_seen) else begin
		$display("timeout: %s never stored to the marker address", name);
		errors++;
	end
	repeat (4) @(posedge clk);
	check_word("write count", 32'(wr_adr.size()), 32'(exp_adr.size()));
	for (i = 0; i < wr_adr.size() && i < exp_adr.size(); i++) begin
		check_word("dbus_adr", wr_adr[i], exp_adr[i]);
		check_word("dbus_dat_w", wr_dat[i], exp_dat[i]);
	end
	tests_run++;
	if (errors != start_errors) begin
		tests_failed++;
	end
	$display("test %-14s %s", name, (errors == start_errors) ? "passed" : "failed");
	prog.delete();
	exp_adr.delete();
	exp_dat.delete();
endtask

task automatic test_reset();
	run_program("reset");
endtask

task automatic test_alu(input string name);
	logic [31:0] sx;
	sx = {{16{alu_imm[15]}}, alu_imm};
	emit_li(5'd1, alu_a);
	emit_li(5'd2, alu_b);
	prog.push_back(enc_r(5'd1, 5'd2, 5'd3, 6'h21));
	emit_store(5'd3, 16'h0200, alu_a + alu_b);
	prog.push_back(enc_r(5'd1, 5'd2, 5'd4, 6'h23));
	emit_store(5'd4, 16'h0204, alu_a - alu_b);
	prog.push_back(enc_r(5'd1, 5'd2, 5'd5, 6'h24));
	emit_store(5'd5, 16'h0208, alu_a & alu_b);
	prog.push_back(enc_r(5'd1, 5'd2, 5'd6, 6'h25));
	emit_store(5'd6, 16'h020c, alu_a | alu_b);
	prog.push_back(enc_r(5'd1, 5'd2, 5'd7, 6'h2a));
	emit_store(5'd7, 16'h0210, ($signed(alu_a) < $signed(alu_b)) ? 32'd1 : 32'd0);
	prog.push_back(enc_r(5'd2, 5'd1, 5'd8, 6'h2a));
	emit_store(5'd8, 16'h0214, ($signed(alu_b) < $signed(alu_a)) ? 32'd1 : 32'd0);
	prog.push_back(enc_i(6'h09, 5'd1, 5'd9, alu_imm));
	emit_store(5'd9, 16'h0218, alu_a + sx);
	prog.push_back(enc_i(6'h0d, 5'd1, 5'd10, alu_imm));
	emit_store(5'd10, 16'h021c, alu_a | {16'h0000, alu_imm});
	prog.push_back(enc_i(6'h0f, 5'd0, 5'd11, alu_imm));
	emit_store(5'd11, 16'h0220, {alu_imm, 16'h0000});
	// dependent chain with no gap
	prog.push_back(enc_r(5'd3, 5'd4, 5'd12, 6'h21));
	prog.push_back(enc_r(5'd12, 5'd1, 5'd13, 6'h23));
	emit_store(5'd13, 16'h0224, (alu_a + alu_b) + (alu_a - alu_b) - alu_a);
	run_program(name);
endtask

task automatic test_load_store();
	logic [31:0] x;
	logic [31:0] y;
	x = lcg_next();
	y = lcg_next();
	emit_li(5'd1, x);
	emit_li(5'd2, y);
	emit_store(5'd1, 16'h0300, x);
	emit_store(5'd2, 16'h0304, y);
	prog.push_back(enc_i(6'h23, 5'd0, 5'd3, 16'h0300));
	prog.push_back(enc_r(5'd3, 5'd2, 5'd4, 6'h21));
	emit_store(5'd4, 16'h0308, x + y);
	prog.push_back(enc_i(6'h23, 5'd0, 5'd5, 16'h0304));
	emit_store(5'd5, 16'h030c, y);
	prog.push_back(enc_i(6'h23, 5'd0, 5'd6, 16'h0310));
	emit_store(5'd6, 16'h0314, 32'h0000_0310 ^ 32'ha5a5_5a5a);
	run_program("load_store");
endtask

task automatic test_branch();
	logic [31:0] a;
	logic [31:0] b;
	a = lcg_next();
	b = a ^ 32'h0000_0010;
	emit_li(5'd1, a);
	emit_li(5'd2, a);
	emit_li(5'd3, b);
	// beq taken over two stores
	prog.push_back(enc_i(6'h04, 5'd1, 5'd2, 16'd2));
	prog.push_back(enc_i(6'h2b, 5'd0, 5'd1, 16'h0400));
	prog.push_back(enc_i(6'h2b, 5'd0, 5'd1, 16'h0404));
	emit_store(5'd2, 16'h0408, a);
	prog.push_back(enc_i(6'h05, 5'd1, 5'd2, 16'd1));
	emit_store(5'd3, 16'h040c, b);
	prog.push_back(enc_i(6'h05, 5'd1, 5'd3, 16'd2));
	prog.push_back(enc_i(6'h2b, 5'd0, 5'd1, 16'h0410));
	prog.push_back(enc_i(6'h2b, 5'd0, 5'd1, 16'h0414));
	emit_store(5'd3, 16'h0418, b);
	prog.push_back(enc_i(6'h04, 5'd1, 5'd3, 16'd1));
	emit_store(5'd2, 16'h041c, a);
	run_program("branch");
endtask

task automatic test_reg_zero();
	logic [31:0] a;
	a = lcg_next();
	emit_li(5'd1, a);
	prog.push_back(enc_r(5'd1, 5'd1, 5'd0, 6'h21));
	prog.push_back(enc_i(6'h09, 5'd0, 5'd0, 16'h0005));
	emit_store(5'd0, 16'h0500, 32'd0);
	prog.push_back(enc_i(6'h0d, 5'd1, 5'd0, 16'hffff));
	prog.push_back(enc_r(5'd0, 5'd1, 5'd2, 6'h21));
	emit_store(5'd2, 16'h0504, a);
	run_program("reg_zero");
endtask

initial begin
	clk = 1'b0;
	rst = 1'b1;
	ibus_dat_r = '0;
	ibus_ack = 1'b0;
	dbus_dat_r = '0;
	dbus_ack = 1'b0;
	random_delay = 1'b0;
	i_cnt = 0;
	i_delay = 1;
	d_cnt = 0;
	d_delay = 1;
	errors = 0;
	tests_run = 0;
	tests_failed = 0;
	lcg_state = 32'hdd1b8cf0;
	alu_a = lcg_next();
	alu_b = lcg_next();
	alu_imm = 16'(lcg_next() >> 8);
	test_reset();
	test_alu("alu");
	test_load_store();
	test_branch();
	test_reg_zero();
	random_delay = 1'b1;
	test_alu("back_pressure");
	$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
	if (errors == 0) begin
		$display("SIMULATION PASSED");
	end else begin
		$display("SIMULATION FAILED");
	end
	$finish;
end

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
	parameter mips_pkg::word_t reset_pc = 32'h0000_0100
) (
	input  wire logic   clk,
	input  wire logic   rst,
	wb_master_if.master ibus,
	wb_master_if.master dbus
);

logic                busy;
logic                redirect;
mips_pkg::word_t     target;
logic                fetch_valid;
mips_pkg::word_t     fetch_instr;
mips_pkg::word_t     fetch_pc;
mips_pkg::reg_addr_t raddr_a;
mips_pkg::reg_addr_t raddr_b;
mips_pkg::word_t     rdata_a;
mips_pkg::word_t     rdata_b;
logic                rf_we;
mips_pkg::reg_addr_t rf_waddr;
mips_pkg::word_t     rf_wdata;
mips_pkg::decoded_t  dec;
mips_pkg::decoded_t  id_ex;

regfile regfile_inst (
	.clk,
	.rst,
	.raddr_a,
	.raddr_b,
	.rdata_a,
	.rdata_b,
	.we    ( rf_we    ),
	.waddr ( rf_waddr ),
	.wdata ( rf_wdata )
);

instr_fetch #(
	.reset_pc ( reset_pc )
) instr_fetch_inst (
	.clk,
	.rst,
	.ibus,
	.take   ( !busy       ),
	.valid  ( fetch_valid ),
	.instr  ( fetch_instr ),
	.pc     ( fetch_pc    ),
	.redirect,
	.target
);

decode decode_inst (
	.valid ( fetch_valid ),
	.instr ( fetch_instr ),
	.pc    ( fetch_pc    ),
	.raddr_a,
	.raddr_b,
	.rdata_a,
	.rdata_b,
	.dec
);

// pipeline between ID and EX
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		id_ex <= mips_pkg::nop_decoded;
	end else if (redirect) begin
		id_ex <= mips_pkg::nop_decoded;
	end else if (!busy) begin
		id_ex <= dec;
	end
end

exec_mem exec_mem_inst (
	.clk,
	.rst,
	.dec   ( id_ex    ),
	.dbus,
	.busy,
	.redirect,
	.target,
	.we    ( rf_we    ),
	.waddr ( rf_waddr ),
	.wdata ( rf_wdata )
);

endmodule

`default_nettype wire

/* hw/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode (
	input  wire logic            valid,
	input  wire mips_pkg::word_t instr,
	input  wire mips_pkg::word_t pc,
	output mips_pkg::reg_addr_t  raddr_a,
	output mips_pkg::reg_addr_t  raddr_b,
	input  wire mips_pkg::word_t rdata_a,
	input  wire mips_pkg::word_t rdata_b,
	output mips_pkg::decoded_t   dec
);

logic [5:0]          opcode;
logic [5:0]          funct;
logic [15:0]         imm16;
mips_pkg::word_t     imm_sext;
mips_pkg::word_t     imm_zext;
mips_pkg::reg_addr_t rt;
mips_pkg::reg_addr_t rd;
mips_pkg::decoded_t  d;
logic                known;

assign opcode = instr[31:26];
assign funct = instr[5:0];
assign imm16 = instr[15:0];
assign imm_sext = {{16{imm16[15]}}, imm16};
assign imm_zext = {16'h0000, imm16};
assign rt = instr[20:16];
assign rd = instr[15:11];

assign raddr_a = instr[25:21];
assign raddr_b = rt;

always_comb begin
	d = mips_pkg::nop_decoded;
	known = 1'b1;
	d.rs_val = rdata_a;
	d.rt_val = rdata_b;
	d.imm = imm_sext;
	d.pc = pc;
	case (opcode)
		6'h00: begin
			d.rd = rd;
			d.reg_write = 1'b1;
			case (funct)
				6'h21: d.op = mips_pkg::alu_add;
				6'h23: d.op = mips_pkg::alu_sub;
				6'h24: d.op = mips_pkg::alu_and;
				6'h25: d.op = mips_pkg::alu_or;
				6'h2a: d.op = mips_pkg::alu_slt;
				default: known = 1'b0;
			endcase
		end
		// addiu
		6'h09: begin
			d.op = mips_pkg::alu_add;
			d.use_imm = 1'b1;
			d.rd = rt;
			d.reg_write = 1'b1;
		end
		// ori and lui take the raw immediate
		6'h0d, 6'h0f: begin
			d.op = (opcode == 6'h0d) ? mips_pkg::alu_or : mips_pkg::alu_lui;
			d.imm = imm_zext;
			d.use_imm = 1'b1;
			d.rd = rt;
			d.reg_write = 1'b1;
		end
		// lw
		6'h23: begin
			d.op = mips_pkg::alu_add;
			d.use_imm = 1'b1;
			d.rd = rt;
			d.reg_write = 1'b1;
			d.load = 1'b1;
		end
		// sw
		6'h2b: begin
			d.op = mips_pkg::alu_add;
			d.use_imm = 1'b1;
			d.store = 1'b1;
		end
		// beq, bne
		6'h04, 6'h05: begin
			d.branch = 1'b1;
			d.branch_ne = opcode[0];
		end
		default: known = 1'b0;
	endcase
end

assign dec = (valid && known) ? d : mips_pkg::nop_decoded;

endmodule

`default_nettype wire

/* hw/exec_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_mem (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire mips_pkg::decoded_t dec,
	wb_master_if.master             dbus,
	output logic                    busy,
	output logic                    redirect,
	output mips_pkg::word_t         target,
	output logic                    we,
	output mips_pkg::reg_addr_t     waddr,
	output mips_pkg::word_t         wdata
);

mips_pkg::word_t opb;
mips_pkg::word_t result;
logic            mem_op;
logic            mem_done;
logic            acked_q;

assign opb = dec.use_imm ? dec.imm : dec.rt_val;

always_comb begin
	case (dec.op)
		mips_pkg::alu_add: result = dec.rs_val + opb;
		mips_pkg::alu_sub: result = dec.rs_val - opb;
		mips_pkg::alu_and: result = dec.rs_val & opb;
		mips_pkg::alu_or:  result = dec.rs_val | opb;
		mips_pkg::alu_slt: result = {31'd0, $signed(dec.rs_val) < $signed(opb)};
		mips_pkg::alu_lui: result = {opb[15:0], 16'h0000};
		default:           result = opb;
	endcase
end

// branch resolves here, younger work is flushed
assign redirect = dec.branch && ((dec.rs_val == dec.rt_val) == dec.branch_ne ? 1'b0 : 1'b1);
assign target = dec.pc + 32'd4 + {dec.imm[29:0], 2'b00};

assign mem_op = dec.load || dec.store;
assign mem_done = dbus.cyc && dbus.ack;

// cyc has to drop for a cycle between back-to-back accesses
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		acked_q <= 1'b0;
	end else begin
		acked_q <= mem_done;
	end
end

assign dbus.cyc = mem_op && !acked_q;
assign dbus.stb = mem_op && !acked_q;
assign dbus.we = dec.store;
assign dbus.sel = 4'hf;
assign dbus.adr = result;
assign dbus.dat_w = dec.rt_val;

assign busy = mem_op && !mem_done;

// loads retire on the ack edge
assign we = dec.reg_write && (!dec.load || mem_done);
assign waddr = dec.rd;
assign wdata = dec.load ? dbus.dat_r : result;

a_no_redirect_when_busy: assert property (@(posedge clk) disable iff (rst)
	!(redirect && busy));

a_cyc_held_to_ack: assert property (@(posedge clk) disable iff (rst)
	(dbus.cyc && !dbus.ack) |=> dbus.cyc);

endmodule

`default_nettype wire

/* hw/instr_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
	parameter mips_pkg::word_t reset_pc = 32'h0000_0100
) (
	input  wire logic            clk,
	input  wire logic            rst,
	wb_master_if.master          ibus,
	input  wire logic            take,
	output logic                 valid,
	output mips_pkg::word_t      instr,
	output mips_pkg::word_t      pc,
	input  wire logic            redirect,
	input  wire mips_pkg::word_t target
);

mips_pkg::word_t pc_q;
mips_pkg::word_t adr_q;
mips_pkg::word_t start_pc;
logic            cyc_q;
logic            discard_q;
logic            start;
logic            done;

assign done = cyc_q && ibus.ack;
// idle and the buffer is free after this edge
assign start = !cyc_q && (!valid || take || redirect);
assign start_pc = redirect ? target : pc_q;

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		cyc_q <= 1'b0;
		discard_q <= 1'b0;
		pc_q <= reset_pc;
		valid <= 1'b0;
	end else begin
		if (start) begin
			cyc_q <= 1'b1;
			pc_q <= start_pc + 32'd4;
		end else begin
			if (done) begin
				cyc_q <= 1'b0;
			end
			if (redirect) begin
				pc_q <= target;
			end
		end
		// word in flight belongs to the old path
		if (done) begin
			discard_q <= 1'b0;
		end else if (redirect && cyc_q) begin
			discard_q <= 1'b1;
		end
		if (redirect) begin
			valid <= 1'b0;
		end else if (done && !discard_q) begin
			valid <= 1'b1;
		end else if (take) begin
			valid <= 1'b0;
		end
	end
end

always_ff @(posedge clk) begin
	if (start) begin
		adr_q <= start_pc;
	end
	if (done) begin
		instr <= ibus.dat_r;
		pc <= adr_q;
	end
end

assign ibus.cyc = cyc_q;
assign ibus.stb = cyc_q;
assign ibus.we = 1'b0;
assign ibus.sel = 4'hf;
assign ibus.adr = adr_q;
assign ibus.dat_w = '0;

// branch targets from execute must stay word aligned too
a_adr_aligned: assert property (@(posedge clk) disable iff (rst)
	ibus.cyc |-> ibus.adr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/mini_mips_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mini_mips_top #(
	parameter mips_pkg::word_t reset_pc = 32'h0000_0100
) (
	input  wire logic            clk,
	input  wire logic            rst,
	output logic                 ibus_cyc,
	output logic                 ibus_stb,
	output mips_pkg::word_t      ibus_adr,
	input  wire mips_pkg::word_t ibus_dat_r,
	input  wire logic            ibus_ack,
	output logic                 dbus_cyc,
	output logic                 dbus_stb,
	output logic                 dbus_we,
	output logic [3:0]           dbus_sel,
	output mips_pkg::word_t      dbus_adr,
	output mips_pkg::word_t      dbus_dat_w,
	input  wire mips_pkg::word_t dbus_dat_r,
	input  wire logic            dbus_ack
);

wb_master_if ibus ();
wb_master_if dbus ();

cpu_core #(
	.reset_pc ( reset_pc )
) cpu_core_inst (
	.clk,
	.rst,
	.ibus,
	.dbus
);

// instruction bus is read only
assign ibus_cyc = ibus.cyc;
assign ibus_stb = ibus.stb;
assign ibus_adr = ibus.adr;
assign ibus.dat_r = ibus_dat_r;
assign ibus.ack = ibus_ack;

assign dbus_cyc = dbus.cyc;
assign dbus_stb = dbus.stb;
assign dbus_we = dbus.we;
assign dbus_sel = dbus.sel;
assign dbus_adr = dbus.adr;
assign dbus_dat_w = dbus.dat_w;
assign dbus.dat_r = dbus_dat_r;
assign dbus.ack = dbus_ack;

endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

typedef logic [31:0] word_t;
typedef logic [4:0]  reg_addr_t;

// operation applied to rs and the second operand
typedef enum logic [2:0] {
	alu_add,
	alu_sub,
	alu_and,
	alu_or,
	alu_slt,
	alu_lui,
	alu_pass
} alu_op_t;

// everything execute needs, operands already read
typedef struct packed {
	alu_op_t   op;
	word_t     rs_val;
	word_t     rt_val;
	word_t     imm;
	logic      use_imm;
	reg_addr_t rd;
	logic      reg_write;
	logic      load;
	logic      store;
	logic      branch;
	logic      branch_ne;
	word_t     pc;
} decoded_t;

// bubble in the pipeline
localparam decoded_t nop_decoded = '{op: alu_pass, default: '0};

endpackage

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire mips_pkg::reg_addr_t raddr_a,
	input  wire mips_pkg::reg_addr_t raddr_b,
	output mips_pkg::word_t          rdata_a,
	output mips_pkg::word_t          rdata_b,
	input  wire logic                we,
	input  wire mips_pkg::reg_addr_t waddr,
	input  wire mips_pkg::word_t     wdata
);

// r0 has no storage
mips_pkg::word_t regs [31:1];

function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
	if (addr == '0) begin
		return '0;
	end
	// retiring write seen by decode in the same cycle
	if (we && addr == waddr) begin
		return wdata;
	end
	return regs[addr];
endfunction

always_ff @(posedge clk) begin
	if (we && waddr != '0) begin
		regs[waddr] <= wdata;
	end
end

always_comb begin
	rdata_a = read_port(raddr_a);
	rdata_b = read_port(raddr_b);
end

a_zero_reads_zero: assert property (@(posedge clk) disable iff (rst)
	(raddr_a == '0 |-> rdata_a == '0) and (raddr_b == '0 |-> rdata_b == '0));

endmodule

`default_nettype wire

/* hw/wb_master_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface wb_master_if ();

logic            cyc;
logic            stb;
logic            we;
logic [3:0]      sel;
mips_pkg::word_t adr;
mips_pkg::word_t dat_w;
mips_pkg::word_t dat_r;
logic            ack;

modport master (
	output cyc, stb, we, sel, adr, dat_w,
	input  dat_r, ack
);

modport slave (
	input  cyc, stb, we, sel, adr, dat_w,
	output dat_r, ack
);

endinterface

`default_nettype wire

/* mini_mips_top.f */
hw/mips_pkg.sv
hw/wb_master_if.sv
hw/regfile.sv
hw/instr_fetch.sv
hw/decode.sv
hw/exec_mem.sv
hw/cpu_core.sv
hw/mini_mips_top.sv
dv/tb_mini_mips.sv
